//--- ddr_memory_controller.f
source/ddr_mem_pkg.sv
source/ddr_user_pkg.sv
source/ddr_req_port.sv
source/ddr_init_seq.sv
source/ddr_bank_tracker.sv
source/ddr_data_path.sv
source/ddr_memory_controller.sv
sim/ddr_clk_gen.sv
sim/ddr_memory_controller_asserts.sv
sim/tb_ddr_memory_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f ddr_memory_controller.f \
  --top-module tb_ddr_memory_controller \
  -o tb_ddr_memory_controller
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_ddr_memory_controller)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

//--- sim/tb_ddr_memory_controller.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ddr_memory_controller;
  import ddr_mem_pkg::*;
  import ddr_user_pkg::*;

  typedef struct {
    bit          bulk;
    user_addr_t  addr;
    bit          we;
    logic [3:0]  be;
    logic [31:0] wdata;
    bit          refresh;
    bit          with_next;
    bit          exp_miss;
    logic [31:0] exp_rdata;
  } entry_t;

  logic        clk_n;
  logic        rst_n;
  logic        refresh_strobe;
  logic        rand_req;
  user_req_t   rand_payload;
  logic        rand_ack;
  logic [31:0] rand_rdata;
  logic        bulk_req;
  user_req_t   bulk_payload;
  logic        bulk_ack;
  logic [31:0] bulk_rdata;
  mem_pins_t   mem;
  logic [31:0] dq_out;
  logic        dq_oe;
  logic [3:0]  dm;
  logic [31:0] dq_in = 32'h0;

  entry_t           tbl[$];
  logic [31:0]      shadow_words[logic [25:0]];
  logic [31:0]      mem_words[logic [25:0]];
  logic [row_w-1:0] model_row[num_banks];
  logic [31:0]      rd_stage[cas_lat];
  mem_pins_t        trace_q[$];
  int               trace_cyc[$];
  int               cyc = 0;
  int               cke_low_cycles = 0;
  int               data_errs = 0;
  int               trace_errs = 0;
  int               proto_errs = 0;
  int               seed = 74217;
  bit               table_ready = 1'b0;

  ddr_clk_gen clk_gen (.clk(clk_n));

  ddr_memory_controller ddr_memory_controller_i (.*);

  // unwritten words read back as a pattern of their own address
  function automatic logic [31:0] fill_word(logic [25:0] a);
    return {a[15:0], a[25:10]} ^ 32'h5ac3_0f96;
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] nw, logic [3:0] be);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) r[8*b +: 8] = nw[8*b +: 8];
    end
    return r;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory model, decodes the pins on the rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk_n) begin
    logic [25:0] key;
    logic [31:0] old;
    cyc = cyc + 1;
    for (int i = cas_lat - 1; i > 0; i--) begin
      rd_stage[i] = rd_stage[i-1];
    end
    rd_stage[0] = 32'h0;
    if (!rst_n) begin
      for (int i = 0; i < cas_lat; i++) begin
        rd_stage[i] = 32'h0;
      end
    end else if (!mem.cke) begin
      cke_low_cycles++;
    end else begin
      if (mem.cmd != cmd_nop) begin
        trace_q.push_back(mem);
        trace_cyc.push_back(cyc);
      end
      if ((rand_ack || bulk_ack) && trace_q.size() < 4) begin
        $display("%0t ns: ack raised before the power-up sequence ended", $time);
        proto_errs++;
      end
      key = {model_row[mem.bank], mem.bank, mem.addr[col_w-1:0]};
      old = mem_words.exists(key) ? mem_words[key] : fill_word(key);
      case (mem.cmd)
        cmd_act: model_row[mem.bank] = mem.addr;
        cmd_wr: begin
          // dm high keeps the stored byte
          for (int b = 0; b < 4; b++) begin
            if (!dm[b]) old[8*b +: 8] = dq_out[8*b +: 8];
          end
          mem_words[key] = old;
          if (dq_oe !== 1'b1) begin
            $display("FAIL %0t ns: dq_oe expected 1 got %b", $time, dq_oe);
            proto_errs++;
          end
        end
        cmd_rd: rd_stage[0] = old;
        default: ;
      endcase
    end
  end

  always @(negedge clk_n) begin
    dq_in <= rd_stage[cas_lat-1];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic void add_entry(bit bulk, int bank, int row, int col, bit we,
                                    logic [3:0] be, bit refresh, bit with_next, bit exp_miss);
    entry_t      e;
    logic [31:0] old;
    e.bulk      = bulk;
    e.addr.bank = bank_w'(bank);
    e.addr.row  = row_w'(row);
    e.addr.col  = col_w'(col);
    e.we        = we;
    e.be        = be;
    e.wdata     = $random(seed);
    e.refresh   = refresh;
    e.with_next = with_next;
    e.exp_miss  = exp_miss;
    old = shadow_words.exists(e.addr) ? shadow_words[e.addr] : fill_word(e.addr);
    if (we) shadow_words[e.addr] = merge_bytes(old, e.wdata, be);
    e.exp_rdata = we ? 32'h0 : old;
    tbl.push_back(e);
  endfunction

  function automatic void build_table();
    // bulk, bank, row, col, we, be, refresh, with next, row miss
    add_entry(1'b0, 1, 5, 3, 1'b1, 4'hf, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 1, 5, 3, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 1, 5, 4, 1'b1, 4'h5, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 1, 5, 4, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 1, 5, 3, 1'b1, 4'h2, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 1, 5, 3, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 1, 9, 3, 1'b1, 4'hf, 1'b0, 1'b0, 1'b1);
    add_entry(1'b0, 1, 9, 3, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 1, 5, 4, 1'b0, 4'h0, 1'b0, 1'b0, 1'b1);
    add_entry(1'b1, 6, 2, 100, 1'b1, 4'hf, 1'b0, 1'b0, 1'b0);
    // refresh closes every row, earlier words must survive it
    add_entry(1'b0, 1, 5, 3, 1'b0, 4'h0, 1'b1, 1'b0, 1'b0);
    add_entry(1'b1, 6, 2, 100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 1, 9, 3, 1'b0, 4'h0, 1'b0, 1'b0, 1'b1);
    // pairs raised on both ports together
    add_entry(1'b0, 2, 7, 8, 1'b1, 4'hf, 1'b0, 1'b1, 1'b0);
    add_entry(1'b1, 3, 7, 8, 1'b1, 4'hf, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 3, 7, 8, 1'b0, 4'h0, 1'b0, 1'b1, 1'b0);
    add_entry(1'b1, 2, 7, 8, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 0, 16383, 511, 1'b1, 4'h8, 1'b0, 1'b1, 1'b0);
    add_entry(1'b1, 1, 9, 3, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 0, 16383, 511, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0);
  endfunction

  task automatic run_access(input entry_t e, output int ack_cyc);
    user_req_t   p;
    logic        ack;
    logic [31:0] got;
    p.addr  = e.addr;
    p.we    = e.we;
    p.be    = e.be;
    p.wdata = e.wdata;
    @(negedge clk_n);
    if (e.bulk) begin
      bulk_payload = p;
      bulk_req     = 1'b1;
    end else begin
      rand_payload = p;
      rand_req     = 1'b1;
    end
    ack = 1'b0;
    while (!ack) begin
      @(negedge clk_n);
      ack = e.bulk ? bulk_ack : rand_ack;
    end
    ack_cyc = cyc;
    got = e.bulk ? bulk_rdata : rand_rdata;
    if (!e.we && got !== e.exp_rdata) begin
      $display("FAIL %0t ns: %s expected %h got %h", $time,
               e.bulk ? "bulk_rdata" : "rand_rdata", e.exp_rdata, got);
      data_errs++;
    end
    if (e.bulk) begin
      bulk_req = 1'b0;
    end else begin
      rand_req = 1'b0;
    end
    while (ack) begin
      @(negedge clk_n);
      ack = e.bulk ? bulk_ack : rand_ack;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // trace checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic expect_cmd(int idx, mem_cmd_e c);
    mem_cmd_e got;
    got = trace_q[idx].cmd;
    if (got != c) begin
      $display("FAIL %0t ns: trace[%0d].cmd expected %s got %s", $time, idx, c.name(), got.name());
      trace_errs++;
    end
  endtask

  task automatic check_power_up();
    expect_cmd(0, cmd_pre);
    expect_cmd(1, cmd_mrs);
    expect_cmd(2, cmd_ref);
    expect_cmd(3, cmd_ref);
    if (trace_q[0].addr[pre_all_bit] !== 1'b1) begin
      $display("FAIL %0t ns: trace[0].addr[10] expected 1 got %b", $time,
               trace_q[0].addr[pre_all_bit]);
      trace_errs++;
    end
    if (trace_q[1].addr !== mode_word) begin
      $display("FAIL %0t ns: trace[1].addr expected %h got %h", $time, mode_word, trace_q[1].addr);
      trace_errs++;
    end
    if (trace_cyc[3] - trace_cyc[2] < t_rfc) begin
      $display("second power-up refresh came too soon after the first");
      trace_errs++;
    end
    if (cke_low_cycles != init_wait) begin
      $display("FAIL %0t ns: cke low cycles expected %0d got %0d", $time, init_wait,
               cke_low_cycles);
      trace_errs++;
    end
  endtask

  function automatic bit has_ref(int from);
    for (int i = from; i < trace_q.size(); i++) begin
      if (trace_q[i].cmd == cmd_ref) return 1'b1;
    end
    return 1'b0;
  endfunction

  // single-bank precharge, then activate of the new row
  function automatic bit pre_then_act(int from, user_addr_t a);
    bit        seen_pre;
    mem_pins_t t;
    seen_pre = 1'b0;
    for (int i = from; i < trace_q.size(); i++) begin
      t = trace_q[i];
      if (t.cmd == cmd_pre && t.bank == a.bank && !t.addr[pre_all_bit]) begin
        seen_pre = 1'b1;
      end else if (seen_pre && t.cmd == cmd_act && t.bank == a.bank && t.addr == a.row) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    entry_t ea;
    entry_t eb;
    int     ca;
    int     cb;
    int     t0;
    int     i;
    rst_n          = 1'b0;
    refresh_strobe = 1'b0;
    rand_req       = 1'b0;
    rand_payload   = '0;
    bulk_req       = 1'b0;
    bulk_payload   = '0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(negedge clk_n);
    rst_n = 1'b1;
    // first request goes up while power-up is still running
    i = 0;
    while (i < tbl.size()) begin
      ea = tbl[i];
      t0 = trace_q.size();
      if (ea.refresh) begin
        @(negedge clk_n);
        refresh_strobe = 1'b1;
        @(negedge clk_n);
        refresh_strobe = 1'b0;
      end
      if (ea.with_next) begin
        eb = tbl[i+1];
        fork
          run_access(ea, ca);
          run_access(eb, cb);
        join
        if ((ea.bulk ? cb : ca) >= (ea.bulk ? ca : cb)) begin
          $display("entry %0d: rand_ack did not rise before bulk_ack", i);
          trace_errs++;
        end
      end else begin
        run_access(ea, ca);
      end
      if (ea.refresh && !has_ref(t0)) begin
        $display("entry %0d: no refresh command after the refresh strobe", i);
        trace_errs++;
      end
      if (ea.exp_miss && !pre_then_act(t0, ea.addr)) begin
        $display("entry %0d: row miss without precharge before activate", i);
        trace_errs++;
      end
      i = i + (ea.with_next ? 2 : 1);
    end
    check_power_up();
    $display("error counts: data %0d, trace %0d, protocol %0d", data_errs, trace_errs,
             proto_errs);
    if (data_errs + trace_errs + proto_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog, table budget plus reset and power-up
  initial begin
    int limit;
    wait (table_ready);
    limit = tbl.size() * 200 + 16 + init_wait + t_rp + t_mrd + 2 * t_rfc + 50;
    repeat (limit) @(posedge clk_n);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/ddr_memory_controller_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_memory_controller_asserts (
  input logic                   clk_n,
  input logic                   rst_n,
  input logic                   rand_req,
  input logic                   rand_ack,
  input logic                   bulk_req,
  input logic                   bulk_ack,
  input ddr_mem_pkg::mem_pins_t mem,
  input logic                   dq_oe
);
  import ddr_mem_pkg::*;

  logic [3:0] since_act;

  // cycles since the last activate, saturating
  always_ff @(posedge clk_n) begin
    if (!rst_n) begin
      since_act <= 4'hf;
    end else if (mem.cmd == cmd_act) begin
      since_act <= 4'd1;
    end else if (since_act != 4'hf) begin
      since_act <= since_act + 4'd1;
    end
  end

  cke_low_nop: assert property (@(posedge clk_n) disable iff (!rst_n)
    !mem.cke |-> mem.cmd == cmd_nop)
    else $error("command issued while cke is low");

  rand_ack_needs_req: assert property (@(posedge clk_n) disable iff (!rst_n)
    $rose(rand_ack) |-> $past(rand_req))
    else $error("rand_ack rose without rand_req");

  bulk_ack_needs_req: assert property (@(posedge clk_n) disable iff (!rst_n)
    $rose(bulk_ack) |-> $past(bulk_req))
    else $error("bulk_ack rose without bulk_req");

  oe_only_on_write: assert property (@(posedge clk_n) disable iff (!rst_n)
    dq_oe |-> mem.cmd == cmd_wr)
    else $error("dq_oe high outside a write command");

  rcd_respected: assert property (@(posedge clk_n) disable iff (!rst_n)
    (mem.cmd == cmd_rd || mem.cmd == cmd_wr) |-> since_act >= 4'(t_rcd))
    else $error("read or write issued too soon after activate");

endmodule

bind ddr_memory_controller ddr_memory_controller_asserts asserts_i (
  .clk_n    (clk_n),
  .rst_n    (rst_n),
  .rand_req (rand_req),
  .rand_ack (rand_ack),
  .bulk_req (bulk_req),
  .bulk_ack (bulk_ack),
  .mem      (mem),
  .dq_oe    (dq_oe)
);

`default_nettype wire

//--- sim/ddr_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_clk_gen (
  output logic clk
);

  // 8 ns period, first rising edge at 4 ns
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- source/ddr_memory_controller.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_memory_controller (
  input  logic                    clk_n,
  input  logic                    rst_n,
  input  logic                    refresh_strobe,
  input  logic                    rand_req,
  input  ddr_user_pkg::user_req_t rand_payload,
  output logic                    rand_ack,
  output logic [31:0]             rand_rdata,
  input  logic                    bulk_req,
  input  ddr_user_pkg::user_req_t bulk_payload,
  output logic                    bulk_ack,
  output logic [31:0]             bulk_rdata,
  output ddr_mem_pkg::mem_pins_t  mem,
  output logic [31:0]             dq_out,
  output logic                    dq_oe,
  output logic [3:0]              dm,
  input  logic [31:0]             dq_in
);

  logic                    rand_pending;
  logic                    bulk_pending;
  ddr_user_pkg::user_req_t rand_q;
  ddr_user_pkg::user_req_t bulk_q;
  logic                    rand_done;
  logic                    bulk_done;
  logic                    init_done;
  logic                    rd_done;
  logic [31:0]             rdata;
  ddr_mem_pkg::mem_pins_t  trk_pins;
  ddr_user_pkg::user_cmd_t dcmd;

  ddr_req_port rand_port (
    .clk_n   (clk_n),
    .rst_n   (rst_n),
    .req     (rand_req),
    .payload (rand_payload),
    .done    (rand_done),
    .ack     (rand_ack),
    .pending (rand_pending),
    .req_q   (rand_q)
  );

  ddr_req_port bulk_port (
    .clk_n   (clk_n),
    .rst_n   (rst_n),
    .req     (bulk_req),
    .payload (bulk_payload),
    .done    (bulk_done),
    .ack     (bulk_ack),
    .pending (bulk_pending),
    .req_q   (bulk_q)
  );

  // owns the pins until power-up is over
  ddr_init_seq init_seq (
    .clk_n     (clk_n),
    .rst_n     (rst_n),
    .user_pins (trk_pins),
    .pins      (mem),
    .init_done (init_done)
  );

  ddr_bank_tracker bank_tracker (
    .clk_n          (clk_n),
    .rst_n          (rst_n),
    .init_done      (init_done),
    .refresh_strobe (refresh_strobe),
    .rand_pending   (rand_pending),
    .rand_req       (rand_q),
    .bulk_pending   (bulk_pending),
    .bulk_req       (bulk_q),
    .rd_done        (rd_done),
    .rand_done      (rand_done),
    .bulk_done      (bulk_done),
    .pins           (trk_pins),
    .dcmd           (dcmd)
  );

  ddr_data_path data_path (
    .clk_n   (clk_n),
    .rst_n   (rst_n),
    .dcmd    (dcmd),
    .dq_in   (dq_in),
    .dq_out  (dq_out),
    .dq_oe   (dq_oe),
    .dm      (dm),
    .rd_done (rd_done),
    .rdata   (rdata)
  );

  // shared read word, each port qualifies it with its own ack
  assign rand_rdata = rdata;
  assign bulk_rdata = rdata;

endmodule

`default_nettype wire

//--- source/ddr_data_path.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_data_path (
  input  logic                    clk_n,
  input  logic                    rst_n,
  input  ddr_user_pkg::user_cmd_t dcmd,
  input  logic [31:0]             dq_in,
  output logic [31:0]             dq_out,
  output logic                    dq_oe,
  output logic [3:0]              dm,
  output logic                    rd_done,
  output logic [31:0]             rdata
);
  import ddr_mem_pkg::*;

  // one bit per read in flight, oldest at the top
  logic [cas_lat-1:0] rd_pipe;
  logic               capture;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side, same cycle as cmd_wr on the pins
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign dq_out = dcmd.wdata;
  assign dq_oe  = dcmd.wr_fire;

  // dm high masks the byte, all masked when idle
  assign dm = dcmd.wr_fire ? ~dcmd.be : 4'hf;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign capture = rd_pipe[cas_lat-1];

  always_ff @(posedge clk_n) begin
    if (!rst_n) begin
      rd_pipe <= '0;
      rd_done <= 1'b0;
    end else begin
      rd_pipe <= {rd_pipe[cas_lat-2:0], dcmd.rd_fire};
      rd_done <= capture;
    end
  end

  // word sampled cas_lat cycles after cmd_rd
  always_ff @(posedge clk_n) begin
    if (capture) begin
      rdata <= dq_in;
    end
  end

endmodule

`default_nettype wire

//--- source/ddr_bank_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_bank_tracker (
  input  logic                    clk_n,
  input  logic                    rst_n,
  input  logic                    init_done,
  input  logic                    refresh_strobe,
  input  logic                    rand_pending,
  input  ddr_user_pkg::user_req_t rand_req,
  input  logic                    bulk_pending,
  input  ddr_user_pkg::user_req_t bulk_req,
  input  logic                    rd_done,
  output logic                    rand_done,
  output logic                    bulk_done,
  output ddr_mem_pkg::mem_pins_t  pins,
  output ddr_user_pkg::user_cmd_t dcmd
);
  import ddr_mem_pkg::*;
  import ddr_user_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_pre_wait,
    s_act_wait,
    s_rd_wait,
    s_fin,
    s_ref_pre_wait,
    s_ref_wait
  } trk_st_e;

  trk_st_e              st;
  logic [3:0]           cnt;
  logic                 sel_bulk;
  logic                 ref_pend;
  user_req_t            cur;
  user_req_t            nxt;
  user_req_t            src;
  logic [num_banks-1:0] row_valid;
  logic [row_w-1:0]     open_row [num_banks];
  logic                 take;
  logic                 start_ref;
  logic                 row_hit;
  logic                 act_now;
  logic                 fin_now;

  function automatic mem_pins_t rw_pins(user_req_t r);
    mem_cmd_e c;
    if (r.we) c = cmd_wr;
    else c = cmd_rd;
    // bit 10 stays low, no auto precharge
    return mk_pins(c, r.addr.bank, mem_addr_w'(r.addr.col));
  endfunction

  function automatic user_cmd_t rw_cmd(user_req_t r);
    user_cmd_t c;
    c.wr_fire = r.we;
    c.rd_fire = !r.we;
    c.be      = r.be;
    c.wdata   = r.wdata;
    return c;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arbitration: refresh, then rand, then bulk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign nxt       = rand_pending ? rand_req : bulk_req;
  assign src       = (st == s_idle) ? nxt : cur;
  assign start_ref = (st == s_idle) && init_done && ref_pend;
  assign take      = (st == s_idle) && init_done && !ref_pend && (rand_pending || bulk_pending);
  assign row_hit   = row_valid[nxt.addr.bank] && (open_row[nxt.addr.bank] == nxt.addr.row);
  assign act_now   = (take && !row_valid[nxt.addr.bank]) || (st == s_pre_wait && cnt == '0);

  // done for a write in the cycle after cmd_wr, for a read when rdata lands
  assign fin_now   = (st == s_fin) || (st == s_rd_wait && rd_done);
  assign rand_done = fin_now && !sel_bulk;
  assign bulk_done = fin_now && sel_bulk;

  always_ff @(posedge clk_n) begin
    if (!rst_n) begin
      st        <= s_idle;
      cnt       <= '0;
      sel_bulk  <= 1'b0;
      ref_pend  <= 1'b0;
      row_valid <= '0;
      pins      <= pins_nop;
      dcmd      <= '0;
    end else begin
      ref_pend     <= refresh_strobe || (ref_pend && !start_ref);
      pins         <= pins_nop;
      dcmd.wr_fire <= 1'b0;
      dcmd.rd_fire <= 1'b0;
      if (cnt != '0) cnt <= cnt - 1'b1;
      case (st)
        s_idle: begin
          if (start_ref) begin
            pins <= mk_pins(cmd_pre, '0, mem_addr_w'(1) << pre_all_bit);
            cnt  <= 4'(t_rp - 1);
            st   <= s_ref_pre_wait;
          end else if (take) begin
            sel_bulk <= !rand_pending;
            if (row_hit) begin
              pins <= rw_pins(src);
              dcmd <= rw_cmd(src);
              st   <= src.we ? s_fin : s_rd_wait;
            end else if (row_valid[src.addr.bank]) begin
              // another row is open in this bank
              pins                      <= mk_pins(cmd_pre, src.addr.bank, '0);
              row_valid[src.addr.bank] <= 1'b0;
              cnt                       <= 4'(t_rp - 1);
              st                        <= s_pre_wait;
            end else begin
              pins                      <= mk_pins(cmd_act, src.addr.bank, src.addr.row);
              row_valid[src.addr.bank] <= 1'b1;
              cnt                       <= 4'(t_rcd - 1);
              st                        <= s_act_wait;
            end
          end
        end
        s_pre_wait: begin
          if (cnt == '0) begin
            pins                      <= mk_pins(cmd_act, src.addr.bank, src.addr.row);
            row_valid[src.addr.bank] <= 1'b1;
            cnt                       <= 4'(t_rcd - 1);
            st                        <= s_act_wait;
          end
        end
        s_act_wait: begin
          if (cnt == '0) begin
            pins <= rw_pins(src);
            dcmd <= rw_cmd(src);
            st   <= src.we ? s_fin : s_rd_wait;
          end
        end
        s_rd_wait: begin
          if (rd_done) st <= s_idle;
        end
        s_fin: st <= s_idle;
        s_ref_pre_wait: begin
          if (cnt == '0) begin
            pins <= mk_pins(cmd_ref, '0, '0);
            cnt  <= 4'(t_rfc - 1);
            st   <= s_ref_wait;
          end
        end
        s_ref_wait: begin
          // every bank is closed after precharge all
          if (cnt == '0) begin
            row_valid <= '0;
            st        <= s_idle;
          end
        end
        default: st <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk_n) begin
    if (take) cur <= nxt;
    if (act_now) open_row[src.addr.bank] <= src.addr.row;
  end

endmodule

`default_nettype wire

//--- source/ddr_init_seq.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_init_seq (
  input  logic                   clk_n,
  input  logic                   rst_n,
  input  ddr_mem_pkg::mem_pins_t user_pins,
  output ddr_mem_pkg::mem_pins_t pins,
  output logic                   init_done
);
  import ddr_mem_pkg::*;

  typedef enum logic [1:0] {
    s_cke,
    s_seq,
    s_done
  } init_st_e;

  localparam logic [1:0] last_step = 2'd3;

  init_st_e   st;
  logic [5:0] cnt;
  logic [1:0] step;
  mem_pins_t  init_pins;

  // step 0 precharge all, 1 mode register, 2 and 3 auto refresh
  function automatic mem_pins_t step_pins(logic [1:0] s);
    case (s)
      2'd0:    return mk_pins(cmd_pre, '0, mem_addr_w'(1) << pre_all_bit);
      2'd1:    return mk_pins(cmd_mrs, '0, mode_word);
      default: return mk_pins(cmd_ref, '0, '0);
    endcase
  endfunction

  function automatic logic [5:0] step_wait(logic [1:0] s);
    case (s)
      2'd0:    return 6'(t_rp - 1);
      2'd1:    return 6'(t_mrd - 1);
      default: return 6'(t_rfc - 1);
    endcase
  endfunction

  always_ff @(posedge clk_n) begin
    if (!rst_n) begin
      st        <= s_cke;
      cnt       <= 6'(init_wait - 1);
      step      <= 2'd0;
      init_pins <= '{cke: 1'b0, cmd: cmd_nop, bank: '0, addr: '0};
    end else begin
      case (st)
        s_cke: begin
          // cke goes high together with the first command
          if (cnt == '0) begin
            init_pins <= step_pins(2'd0);
            cnt       <= step_wait(2'd0);
            st        <= s_seq;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        s_seq: begin
          init_pins <= pins_nop;
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else if (step == last_step) begin
            st <= s_done;
          end else begin
            step      <= step + 1'b1;
            init_pins <= step_pins(step + 1'b1);
            cnt       <= step_wait(step + 1'b1);
          end
        end
        default: ;
      endcase
    end
  end

  assign init_done = (st == s_done);
  assign pins      = init_done ? user_pins : init_pins;

endmodule

`default_nettype wire

//--- source/ddr_req_port.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_req_port (
  input  logic                    clk_n,
  input  logic                    rst_n,
  input  logic                    req,
  input  ddr_user_pkg::user_req_t payload,
  input  logic                    done,
  output logic                    ack,
  output logic                    pending,
  output ddr_user_pkg::user_req_t req_q
);

  logic accept;

  // new request only once the previous handshake has fully closed
  assign accept = req && !pending && !ack;

  always_ff @(posedge clk_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
      ack     <= 1'b0;
    end else begin
      if (accept) begin
        pending <= 1'b1;
      end else if (pending && done) begin
        pending <= 1'b0;
        ack     <= 1'b1;
      end else if (ack && !req) begin
        ack <= 1'b0;
      end
    end
  end

  // request is held stable by the requester, one copy is enough
  always_ff @(posedge clk_n) begin
    if (accept) begin
      req_q <= payload;
    end
  end

endmodule

`default_nettype wire

//--- source/ddr_user_pkg.sv
`default_nettype none

package ddr_user_pkg;

  localparam int num_banks = 8;

  localparam int col_w  = 9;
  localparam int row_w  = 14;
  localparam int bank_w = 3;

  // 26-bit word address, row in the top bits
  typedef struct packed {
    logic [row_w-1:0]  row;
    logic [bank_w-1:0] bank;
    logic [col_w-1:0]  col;
  } user_addr_t;

  typedef struct packed {
    user_addr_t  addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } user_req_t;

  // tracker to data path, valid in the cycle the command is on the pins
  typedef struct packed {
    logic        wr_fire;
    logic        rd_fire;
    logic [3:0]  be;
    logic [31:0] wdata;
  } user_cmd_t;

endpackage

`default_nettype wire

//--- source/ddr_mem_pkg.sv
`default_nettype none

package ddr_mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pin side of the controller
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int mem_addr_w = 14;
  localparam int mem_bank_w = 3;

  // ras/cas/we, all active low on the pins
  typedef enum logic [2:0] {
    cmd_mrs = 3'b000,
    cmd_ref = 3'b001,
    cmd_pre = 3'b010,
    cmd_act = 3'b011,
    cmd_wr  = 3'b100,
    cmd_rd  = 3'b101,
    cmd_nop = 3'b111
  } mem_cmd_e;

  typedef struct packed {
    logic                  cke;
    mem_cmd_e              cmd;
    logic [mem_bank_w-1:0] bank;
    logic [mem_addr_w-1:0] addr;
  } mem_pins_t;

  // timing in clk_n cycles
  localparam int t_rcd     = 2;
  localparam int t_rp      = 2;
  localparam int t_mrd     = 2;
  localparam int cas_lat   = 2;
  localparam int t_rfc     = 8;
  localparam int init_wait = 40;

  localparam int pre_all_bit = 10;

  // burst length 1, sequential, cas latency in bits 6:4
  localparam logic [mem_addr_w-1:0] mode_word = mem_addr_w'({3'(cas_lat), 4'b0000});

  localparam mem_pins_t pins_nop = '{cke: 1'b1, cmd: cmd_nop, bank: '0, addr: '0};

  function automatic mem_pins_t mk_pins(mem_cmd_e cmd, logic [mem_bank_w-1:0] bank,
                                        logic [mem_addr_w-1:0] addr);
    mem_pins_t p;
    p.cke  = 1'b1;
    p.cmd  = cmd;
    p.bank = bank;
    p.addr = addr;
    return p;
  endfunction

endpackage

`default_nettype wire
